// ==== mduPkg.sv ====
package mduPkg;

    localparam int DATA_W     = 32;
    localparam int PRF_ADDR_W = 6;
    localparam int ROB_ID_W   = 5;

    typedef enum logic [2:0] {
        NOP,
        MULT,
        MULTU,
        DIV,
        DIVU
    } MduOp;

    // one micro-op, hi or lo half of an instruction
    typedef struct packed {
        logic                  valid;
        MduOp                  op;
        logic [PRF_ADDR_W-1:0] dstPAddr;
        logic [ROB_ID_W-1:0]   robId;
    } UopBundle;

    // rs1Data is the dividend, rs0Data the divisor
    typedef struct packed {
        UopBundle            uopHi;
        UopBundle            uopLo;
        logic [DATA_W-1:0]   rs0Data;
        logic [DATA_W-1:0]   rs1Data;
    } MduReq;

    // hi is product upper half or remainder, lo is product lower half or quotient
    typedef struct packed {
        UopBundle            uopHi;
        UopBundle            uopLo;
        logic [DATA_W-1:0]   hiData;
        logic [DATA_W-1:0]   loData;
    } MduResult;

    typedef struct packed {
        logic                  wen;
        logic [PRF_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     wdata;
    } PrfWriteInfo;

    typedef struct packed {
        logic                setFinish;
        logic [ROB_ID_W-1:0] id;
    } RobFinish;

endpackage

// ==== mulPipe.sv ====
`timescale 1ns/100ps

module mulPipe #(
    parameter int MUL_LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             inVld,
    input  mduPkg::MduReq    in,
    output logic             outVld,
    output mduPkg::MduResult out
);
    import mduPkg::*;

    logic                     isSigned;
    logic signed [DATA_W:0]   opA;
    logic signed [DATA_W:0]   opB;
    logic signed [2*DATA_W+1:0] prodNow;
    logic [MUL_LATENCY-1:0]   vldPipe;
    logic [2*DATA_W-1:0]      prodPipe [MUL_LATENCY];
    UopBundle                 hiPipe   [MUL_LATENCY];
    UopBundle                 loPipe   [MUL_LATENCY];

    assign isSigned = in.uopHi.op == MULT;
    assign opA      = {isSigned & in.rs0Data[DATA_W-1], in.rs0Data}; // sign or zero extend
    assign opB      = {isSigned & in.rs1Data[DATA_W-1], in.rs1Data};
    assign prodNow  = opA * opB;

    always_ff @(posedge clk) begin
        if (rst) begin
            vldPipe <= '0;
        end else begin
            vldPipe[0] <= inVld;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                vldPipe[i] <= vldPipe[i-1];
            end
        end
    end

    // product and micro-ops move in lockstep
    always_ff @(posedge clk) begin
        prodPipe[0] <= prodNow[2*DATA_W-1:0];
        hiPipe[0]   <= in.uopHi;
        loPipe[0]   <= in.uopLo;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            prodPipe[i] <= prodPipe[i-1];
            hiPipe[i]   <= hiPipe[i-1];
            loPipe[i]   <= loPipe[i-1];
        end
    end

    assign outVld     = vldPipe[MUL_LATENCY-1];
    assign out.uopHi  = hiPipe[MUL_LATENCY-1];
    assign out.uopLo  = loPipe[MUL_LATENCY-1];
    assign out.hiData = prodPipe[MUL_LATENCY-1][2*DATA_W-1:DATA_W];
    assign out.loData = prodPipe[MUL_LATENCY-1][DATA_W-1:0];

endmodule

// ==== divIter.sv ====
`timescale 1ns/100ps

module divIter (
    input  logic             clk,
    input  logic             rst,
    input  logic             inVld,
    input  mduPkg::MduReq    in,
    input  logic             ack,
    output logic             busy,
    output logic             outVld,
    output mduPkg::MduResult out
);
    import mduPkg::*;

    localparam int STEP_W = $clog2(DATA_W);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(DATA_W - 1);

    typedef enum logic [1:0] {
        dvIdle,
        dvRun,
        dvFix,
        dvDone
    } DivPhase;

    DivPhase             phase;
    logic [STEP_W-1:0]   step;
    logic [DATA_W-1:0]   rem;
    logic [DATA_W-1:0]   quo;
    logic [DATA_W-1:0]   dsr;
    logic                negQ;
    logic                negR;
    UopBundle            uopHi;
    UopBundle            uopLo;
    logic                isSigned;
    logic                dvdNeg;
    logic                dsrNeg;
    logic [DATA_W-1:0]   dvdMag;
    logic [DATA_W-1:0]   dsrMag;
    logic [DATA_W:0]     remShift;
    logic [DATA_W+1:0]   diff;

    assign isSigned = in.uopHi.op == DIV;
    assign dvdNeg   = isSigned & in.rs1Data[DATA_W-1];
    assign dsrNeg   = isSigned & in.rs0Data[DATA_W-1];
    assign dvdMag   = dvdNeg ? -in.rs1Data : in.rs1Data;
    assign dsrMag   = dsrNeg ? -in.rs0Data : in.rs0Data; // 0x80000000 stays as magnitude

    // one restoring step
    assign remShift = {rem, quo[DATA_W-1]};
    assign diff     = {1'b0, remShift} - {2'b0, dsr};

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= dvIdle;
            step  <= '0;
        end else begin
            case (phase)
                dvIdle: begin
                    if (inVld) begin
                        phase <= dvRun;
                        step  <= '0;
                    end
                end
                dvRun: begin
                    step <= step + 1'b1;
                    if (step == STEP_LAST) begin
                        phase <= dvFix;
                    end
                end
                dvFix: begin
                    phase <= dvDone;
                end
                default: begin
                    if (ack) begin
                        phase <= dvIdle; // released by writeback hi
                    end
                end
            endcase
        end
    end

    // divide by zero and overflow fall out of the plain algorithm
    always_ff @(posedge clk) begin
        case (phase)
            dvIdle: begin
                if (inVld) begin
                    rem   <= '0;
                    quo   <= dvdMag;
                    dsr   <= dsrMag;
                    negQ  <= dvdNeg ^ dsrNeg;
                    negR  <= dvdNeg;
                    uopHi <= in.uopHi;
                    uopLo <= in.uopLo;
                end
            end
            dvRun: begin
                if (!diff[DATA_W+1]) begin
                    rem <= diff[DATA_W-1:0];
                    quo <= {quo[DATA_W-2:0], 1'b1};
                end else begin
                    rem <= remShift[DATA_W-1:0]; // restore
                    quo <= {quo[DATA_W-2:0], 1'b0};
                end
            end
            dvFix: begin
                if (negR) begin
                    rem <= -rem;
                end
                if (negQ) begin
                    quo <= -quo;
                end
            end
            default: ;
        endcase
    end

    assign busy       = phase != dvIdle;
    assign outVld     = phase == dvDone;
    assign out.uopHi  = uopHi;
    assign out.uopLo  = uopLo;
    assign out.hiData = rem;
    assign out.loData = quo;

endmodule

// ==== mduIssue.sv ====
`timescale 1ns/100ps

module mduIssue #(
    parameter int MUL_LATENCY = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          reqVld,
    input  mduPkg::MduReq req,
    input  logic          divBusy,
    input  logic          divOutVld,
    output logic          reqRdy,
    output logic          mulVld,
    output logic          divVld,
    output mduPkg::MduReq issued
);
    import mduPkg::*;

    localparam int DIV_LAT = DATA_W + 2; // issue edge to divider result edge
    localparam int LEFT_W  = $clog2(DIV_LAT + 1);

    logic                   live;
    logic                   isMul;
    logic                   isDiv;
    logic                   take;
    logic                   mulOk;
    logic                   divOk;
    logic                   divDue;
    logic                   mulAge;
    logic [LEFT_W-1:0]      divLeft;

    assign isMul = req.uopHi.valid && (req.uopHi.op inside {MULT, MULTU});
    assign isDiv = req.uopHi.valid && (req.uopHi.op inside {DIV, DIVU});

    // a multiply taken now must land before the divide result shows up
    assign divDue = (divLeft != '0) && (int'(divLeft) <= MUL_LATENCY + 1);
    assign mulOk  = !mulAge && !divOutVld && !divDue;
    assign divOk  = !divBusy && !divVld;

    always_comb begin
        if (isMul) begin
            reqRdy = live && mulOk;
        end else if (isDiv) begin
            reqRdy = live && divOk;
        end else begin
            reqRdy = live; // nop is taken and dropped
        end
    end

    assign take   = reqVld && reqRdy;
    assign mulVld = mulAge;

    always_ff @(posedge clk) begin
        if (rst) begin
            live    <= 1'b0;
            mulAge  <= 1'b0;
            divVld  <= 1'b0;
            divLeft <= '0;
        end else begin
            live    <= 1'b1;
            mulAge  <= take && isMul; // multiply taken last cycle
            divVld  <= take && isDiv;
            if (take && isDiv) begin
                divLeft <= LEFT_W'(DIV_LAT);
            end else if (divLeft != '0) begin
                divLeft <= divLeft - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            issued <= req;
        end
    end

endmodule

// ==== mduWriteback.sv ====
`timescale 1ns/100ps

module mduWriteback (
    input  logic                clk,
    input  logic                rst,
    input  logic                mulVld,
    input  mduPkg::MduResult    mulRes,
    input  logic                divVld,
    input  mduPkg::MduResult    divRes,
    output logic                divAck,
    output mduPkg::PrfWriteInfo wbData,
    output mduPkg::RobFinish    robFinish
);
    import mduPkg::*;

    typedef enum logic [2:0] {
        idle,
        mulHi,
        mulLo,
        divHi,
        divLo
    } WbState;

    WbState   state;
    WbState   nextState;
    MduResult held;

    always_comb begin
        nextState = idle;
        case (state)
            mulHi: begin
                nextState = mulLo;
            end
            divHi: begin
                nextState = divLo;
            end
            default: begin
                if (mulVld) begin
                    nextState = mulHi; // multiply has fixed timing, goes first
                end else if (divVld) begin
                    nextState = divHi;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (nextState == mulHi) begin
            held <= mulRes;
        end else if (nextState == divHi) begin
            held <= divRes;
        end
    end

    always_comb begin
        wbData    = '0;
        robFinish = '0;
        case (state)
            mulHi, divHi: begin
                wbData.wen          = 1'b1;
                wbData.rd           = held.uopHi.dstPAddr;
                wbData.wdata        = held.hiData;
                robFinish.setFinish = 1'b1;
                robFinish.id        = held.uopHi.robId;
            end
            mulLo, divLo: begin
                wbData.wen          = 1'b1;
                wbData.rd           = held.uopLo.dstPAddr;
                wbData.wdata        = held.loData;
                robFinish.setFinish = 1'b1;
                robFinish.id        = held.uopLo.robId;
            end
            default: ;
        endcase
    end

    assign divAck = state == divHi; // frees the divider for the next one

endmodule

// ==== mduTop.sv ====
`timescale 1ns/100ps

module mduTop #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqVld,
    input  mduPkg::MduReq       req,
    output logic                reqRdy,
    output mduPkg::PrfWriteInfo wbData,
    output mduPkg::RobFinish    robFinish
);
    import mduPkg::*;

    MduReq    issued;
    logic     mulVld;
    logic     divVld;
    logic     divBusy;
    logic     divOutVld;
    logic     divAck;
    logic     mulOutVld;
    MduResult mulOut;
    MduResult divOut;

    mduIssue #(
        .MUL_LATENCY (MUL_LATENCY)
    ) issue (
        .clk       (clk),
        .rst       (rst),
        .reqVld    (reqVld),
        .req       (req),
        .divBusy   (divBusy),
        .divOutVld (divOutVld),
        .reqRdy    (reqRdy),
        .mulVld    (mulVld),
        .divVld    (divVld),
        .issued    (issued)
    );

    mulPipe #(
        .MUL_LATENCY (MUL_LATENCY)
    ) mul (
        .clk    (clk),
        .rst    (rst),
        .inVld  (mulVld),
        .in     (issued),
        .outVld (mulOutVld),
        .out    (mulOut)
    );

    divIter div (
        .clk    (clk),
        .rst    (rst),
        .inVld  (divVld),
        .in     (issued),
        .ack    (divAck),
        .busy   (divBusy),
        .outVld (divOutVld),
        .out    (divOut)
    );

    mduWriteback wb (
        .clk       (clk),
        .rst       (rst),
        .mulVld    (mulOutVld),
        .mulRes    (mulOut),
        .divVld    (divOutVld),
        .divRes    (divOut),
        .divAck    (divAck),
        .wbData    (wbData),
        .robFinish (robFinish)
    );

endmodule

// ==== mduTb.sv ====
`timescale 1ns/100ps

module mduTb;
    import mduPkg::*;

    localparam int MUL_LAT     = 3;
    localparam int RAND_N      = 200;
    localparam int DIRECTED_N  = 50;  // directed sections stay below this
    localparam int CYCLE_LIMIT = 40 * (DIRECTED_N + RAND_N) + 200;
    localparam int DIV_BOUND   = 50;  // divide accept to hi write with multiplies around

    // one expected hi/lo write pair
    typedef struct packed {
        logic        isMul;
        UopBundle    hi;
        UopBundle    lo;
        logic [31:0] hiData;
        logic [31:0] loData;
        logic [31:0] acceptCyc;
    } ExpPair;

    logic        clk;
    logic        rst;
    logic        reqVld;
    MduReq       req;
    logic        reqRdy;
    PrfWriteInfo wbData;
    RobFinish    robFinish;

    int          seed;
    int          cyc;
    string       testName;
    ExpPair      mulQ[$];
    ExpPair      divQ[$];
    ExpPair      cur;
    logic        inPair;
    logic [4:0]  nextId;
    int          lastAccCyc;
    int          divSeenAtAcc;
    int          lastDivHiCyc;

    mduTop #(
        .MUL_LATENCY (MUL_LAT)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .reqVld    (reqVld),
        .req       (req),
        .reqRdy    (reqRdy),
        .wbData    (wbData),
        .robFinish (robFinish)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic failNow(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at cycle %0d", cyc);
    endtask

    task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            failNow($sformatf("Mismatch in %s: %s expected %h actual %h",
                              testName, what, exp, act));
    endtask

    // hi = upper product or remainder, lo = lower product or quotient
    function automatic logic [63:0] refCalc(input MduOp op, input logic [31:0] rs0,
                                             input logic [31:0] rs1);
        longint sa;
        longint sb;
        logic [31:0] q;
        logic [31:0] r;
        sa = $signed(rs0);
        sb = $signed(rs1);
        case (op)
            MULT:  return sa * sb;
            MULTU: return {32'b0, rs0} * {32'b0, rs1};
            DIVU: begin
                q = (rs0 == 0) ? 32'hFFFF_FFFF : rs1 / rs0;
                r = (rs0 == 0) ? rs1 : rs1 % rs0;
            end
            default: begin
                if (rs0 == 0) begin
                    q = (sb < 0) ? 32'd1 : 32'hFFFF_FFFF;
                    r = rs1;
                end else if (rs1 == 32'h8000_0000 && rs0 == 32'hFFFF_FFFF) begin
                    q = 32'h8000_0000;
                    r = 32'd0;
                end else begin
                    q = 32'(sb / sa); // rs1 is the dividend
                    r = 32'(sb % sa);
                end
            end
        endcase
        return {r, q};
    endfunction

    function automatic MduReq makeReq(input MduOp op, input logic [31:0] rs0,
                                      input logic [31:0] rs1);
        MduReq r;
        r.uopHi.valid    = 1'b1;
        r.uopHi.op       = op;
        r.uopHi.dstPAddr = 6'($random(seed));
        r.uopHi.robId    = nextId;
        r.uopLo          = r.uopHi;
        r.uopLo.dstPAddr = 6'($random(seed));
        r.uopLo.robId    = nextId + 5'd1;
        nextId           = nextId + 5'd2;
        r.rs0Data        = rs0;
        r.rs1Data        = rs1;
        return r;
    endfunction

    function automatic logic [31:0] randOperand();
        case ($unsigned($random(seed)) % 8)
            0:       return 32'd0;
            1:       return 32'h8000_0000;
            2:       return 32'hFFFF_FFFF;
            default: return $random(seed);
        endcase
    endfunction

    function automatic MduReq randReq();
        MduOp op;
        case ($unsigned($random(seed)) % 9)
            0, 1:    op = MULT;
            2, 3:    op = MULTU;
            4, 5:    op = DIV;
            6, 7:    op = DIVU;
            default: op = NOP;
        endcase
        return makeReq(op, randOperand(), randOperand());
    endfunction

    // holds the request until reqRdy, books the expected pair
    task automatic sendReq(input MduReq r);
        ExpPair      e;
        logic [63:0] res;
        reqVld = 1'b1;
        req    = r;
        #1;
        while (!reqRdy) begin
            @(negedge clk);
            #1;
        end
        lastAccCyc   = cyc + 1; // taken at the coming rising edge
        divSeenAtAcc = lastDivHiCyc;
        if (r.uopHi.valid && r.uopHi.op != NOP) begin
            res         = refCalc(r.uopHi.op, r.rs0Data, r.rs1Data);
            e.isMul     = r.uopHi.op inside {MULT, MULTU};
            e.hi        = r.uopHi;
            e.lo        = r.uopLo;
            e.hiData    = res[63:32];
            e.loData    = res[31:0];
            e.acceptCyc = lastAccCyc;
            if (e.isMul) begin
                mulQ.push_back(e);
            end else begin
                divQ.push_back(e);
            end
        end
        @(negedge clk);
        reqVld = 1'b0;
    endtask

    task automatic drain();
        while (mulQ.size() != 0 || divQ.size() != 0 || inPair) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // a hi write must match the oldest multiply or the oldest divide
    task automatic takeHi();
        if (mulQ.size() != 0 && mulQ[0].hi.robId == robFinish.id) begin
            cur = mulQ.pop_front();
        end else if (divQ.size() != 0 && divQ[0].hi.robId == robFinish.id) begin
            cur          = divQ.pop_front();
            lastDivHiCyc = cyc;
        end else begin
            failNow($sformatf("write to p%0d with ROB id %0d has no expected entry",
                              wbData.rd, robFinish.id));
        end
        checkValue("hi rd", cur.hi.dstPAddr, wbData.rd);
        checkValue("hi data", cur.hiData, wbData.wdata);
        if (cur.isMul) begin
            checkValue("hi write cycle", cur.acceptCyc + MUL_LAT + 1, cyc);
        end
        inPair = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            assert (wbData.wen === robFinish.setFinish) else
                failNow("register write and ROB finish not raised together");
            if (inPair) begin
                assert (wbData.wen) else
                    failNow($sformatf("lo write of ROB id %0d missing", cur.lo.robId));
                checkValue("lo rd", cur.lo.dstPAddr, wbData.rd);
                checkValue("lo ROB id", cur.lo.robId, robFinish.id);
                checkValue("lo data", cur.loData, wbData.wdata);
                inPair = 1'b0;
            end else if (wbData.wen) begin
                takeHi();
            end
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            failNow($sformatf("timeout after %0d cycles in %s", cyc, testName));
        end
    end

    initial begin
        MduReq r;
        int    divAcc;
        int    pendMulAcc;
        seed         = 55;
        cyc          = 0;
        inPair       = 1'b0;
        nextId       = '0;
        lastAccCyc   = 0;
        divSeenAtAcc = 0;
        lastDivHiCyc = 0;
        rst          = 1'b1;
        reqVld       = 1'b0;
        req          = '0;

        testName = "reset";
        repeat (16) begin
            @(negedge clk);
            assert (!wbData.wen && !robFinish.setFinish && !reqRdy) else
                failNow("outputs active during reset");
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!wbData.wen && !robFinish.setFinish) else
                failNow("write or finish raised with no request");
        end
        assert (reqRdy === 1'b1) else failNow("reqRdy did not rise after reset");

        testName = "directed multiply";
        sendReq(makeReq(MULT, 32'd7, 32'd6));
        sendReq(makeReq(MULT, 32'hFFFF_FFF9, 32'd6));
        sendReq(makeReq(MULT, 32'h8000_0000, 32'h8000_0000));
        sendReq(makeReq(MULT, 32'h7FFF_FFFF, 32'hFFFF_FFFF));
        sendReq(makeReq(MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF));
        sendReq(makeReq(MULTU, 32'h8000_0000, 32'd2));
        drain();

        testName = "directed divide"; // rs0 divisor, rs1 dividend
        sendReq(makeReq(DIV, 32'd7, 32'hFFFF_FF9C));
        sendReq(makeReq(DIV, 32'hFFFF_FFF9, 32'd100));
        sendReq(makeReq(DIV, 32'hFFFF_FFF9, 32'hFFFF_FF9C));
        sendReq(makeReq(DIV, 32'd0, 32'hFFFF_FFFB));
        sendReq(makeReq(DIV, 32'hFFFF_FFFF, 32'h8000_0000));
        sendReq(makeReq(DIVU, 32'd0, 32'd12345));
        sendReq(makeReq(DIVU, 32'd3, 32'hFFFF_FFFF));
        sendReq(makeReq(DIVU, 32'hFFFF_FFFF, 32'd5));
        drain();

        testName = "back-to-back multiply";
        sendReq(makeReq(MULT, $random(seed), $random(seed)));
        for (int i = 0; i < 3; i++) begin
            r      = makeReq(MULTU, $random(seed), $random(seed));
            reqVld = 1'b1;
            req    = r;
            #1;
            assert (!reqRdy) else failNow("reqRdy high in the cycle after an accepted multiply");
            sendReq(r);
        end
        drain();

        testName = "divide pending";
        sendReq(makeReq(DIV, 32'd3, 32'hFFFF_0000));
        divAcc     = lastAccCyc;
        pendMulAcc = 0;
        while (divSeenAtAcc <= divAcc) begin
            sendReq(makeReq(MULTU, $random(seed), $random(seed)));
            if (divSeenAtAcc <= divAcc) begin
                pendMulAcc = lastAccCyc;
            end
        end
        drain();
        assert (lastDivHiCyc > divAcc && lastDivHiCyc - divAcc <= DIV_BOUND) else
            failNow("divide did not finish in time while multiplies were offered");
        assert (pendMulAcc + MUL_LAT + 1 < lastDivHiCyc) else
            failNow("a multiply was taken after the pending divide was due");

        testName = "random stream";
        for (int n = 0; n < RAND_N; n++) begin
            sendReq(randReq());
            if ($unsigned($random(seed)) % 4 == 0) begin
                @(negedge clk); // idle gap
            end
        end
        drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
mduPkg.sv
mulPipe.sv
divIter.sv
mduIssue.sv
mduWriteback.sv
mduTop.sv
mduTb.sv

// ==== Bender.yml ====
package:
  name: mdu

sources:
  - mduPkg.sv
  - mulPipe.sv
  - divIter.sv
  - mduIssue.sv
  - mduWriteback.sv
  - mduTop.sv
  - target: simulation
    files:
      - mduTb.sv
